//--- Makefile
TOP := conv_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f renkon.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -Fqx '** PASS **'

clean:
	rm -rf obj_dir

//--- renkon.f
src/conv_types_pkg.sv
src/conv_regs_pkg.sv
src/mem_sp.sv
src/cfg_axil_slave.sv
src/linebuf.sv
src/conv_mac.sv
src/conv_out.sv
src/conv_top.sv
verif/conv_tb.sv

//--- src/cfg_axil_slave.sv
`timescale 1ns/1ps

module cfg_axil_slave #(
  parameter int KSIZE = 3
) (
  input  logic                                    clk,
  input  logic                                    xrst,
  input  conv_regs_pkg::axil_req_t                axil_req,
  output conv_regs_pkg::axil_rsp_t                axil_rsp,
  output conv_regs_pkg::cfg_t                     cfg,
  output conv_types_pkg::coef_t [KSIZE*KSIZE-1:0] weights,
  output logic                                    start,
  input  logic                                    busy,
  input  logic                                    done
);

  import conv_types_pkg::*;
  import conv_regs_pkg::*;

  localparam int NW = KSIZE * KSIZE;

  logic               wr_fire;
  logic               rd_fire;
  logic               r_bvalid;
  logic [1:0]         r_bresp;
  logic               r_rvalid;
  logic [AXIL_DW-1:0] r_rdata;
  logic [1:0]         r_rresp;
  logic [AXIL_DW-1:0] rd_data;
  logic               r_start;
  size_t              r_img_size;
  shift_t             r_shift;
  coef_t [NW-1:0]     r_weights;

  function automatic logic is_mapped(input logic [AXIL_AW-1:0] addr);
    logic hit;
    hit = addr == REG_CTRL || addr == REG_STATUS || addr == REG_IMG_SIZE || addr == REG_SHIFT;
    for (int k = 0; k < NW; k++) begin
      if (addr == AXIL_AW'(REG_WEIGHT_BASE + 4 * k)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // byte lanes without a strobe keep the current register value
  function automatic logic [AXIL_DW-1:0] merge(input logic [AXIL_DW-1:0] cur,
                                               input logic [AXIL_DW-1:0] wdata,
                                               input logic [3:0]         strb);
    logic [AXIL_DW-1:0] mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (cur & ~mask) | (wdata & mask);
  endfunction

  // address and data are taken together, one response outstanding at most
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !r_bvalid;
  assign rd_fire = axil_req.arvalid && !r_rvalid;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_bvalid <= 1'b0;
      r_bresp  <= RESP_OKAY;
    end else if (wr_fire) begin
      r_bvalid <= 1'b1;
      r_bresp  <= is_mapped(axil_req.awaddr) ? RESP_OKAY : RESP_SLVERR;
    end else if (axil_req.bready) begin
      r_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_start    <= 1'b0;
      r_img_size <= '0;
      r_shift    <= '0;
      r_weights  <= '0;
    end else begin
      r_start <= wr_fire && axil_req.awaddr == REG_CTRL && axil_req.wstrb[0]
                 && axil_req.wdata[0] && !busy;
      if (wr_fire && !busy) begin // configuration is frozen while an image runs
        case (axil_req.awaddr)
          REG_IMG_SIZE: r_img_size <= size_t'(merge(AXIL_DW'(r_img_size),
                                                    axil_req.wdata, axil_req.wstrb));
          REG_SHIFT:    r_shift <= shift_t'(merge(AXIL_DW'(r_shift),
                                                  axil_req.wdata, axil_req.wstrb));
          default: ;
        endcase
        for (int k = 0; k < NW; k++) begin
          if (axil_req.awaddr == AXIL_AW'(REG_WEIGHT_BASE + 4 * k)) begin
            r_weights[k] <= coef_t'(merge(AXIL_DW'(r_weights[k]),
                                          axil_req.wdata, axil_req.wstrb));
          end
        end
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (axil_req.araddr)
      REG_STATUS:   rd_data = {{(AXIL_DW-2){1'b0}}, done, busy};
      REG_IMG_SIZE: rd_data = AXIL_DW'(r_img_size);
      REG_SHIFT:    rd_data = AXIL_DW'(r_shift);
      default: ;
    endcase
    for (int k = 0; k < NW; k++) begin
      if (axil_req.araddr == AXIL_AW'(REG_WEIGHT_BASE + 4 * k)) begin
        rd_data = AXIL_DW'($signed(r_weights[k])); // weights read back sign-extended
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_rvalid <= 1'b0;
    end else if (rd_fire) begin
      r_rvalid <= 1'b1;
    end else if (axil_req.rready) begin
      r_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      r_rdata <= rd_data;
      r_rresp <= is_mapped(axil_req.araddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign axil_rsp.awready = wr_fire;
  assign axil_rsp.wready  = wr_fire;
  assign axil_rsp.bvalid  = r_bvalid;
  assign axil_rsp.bresp   = r_bresp;
  assign axil_rsp.arready = rd_fire;
  assign axil_rsp.rvalid  = r_rvalid;
  assign axil_rsp.rdata   = r_rdata;
  assign axil_rsp.rresp   = r_rresp;

  assign cfg.img_size = r_img_size;
  assign cfg.shift    = r_shift;
  assign weights      = r_weights;
  assign start        = r_start;

endmodule

//--- src/conv_mac.sv
`timescale 1ns/1ps

module conv_mac #(
  parameter int KSIZE = 3
) (
  input  logic                                    clk,
  input  logic                                    xrst,
  input  logic                                    win_valid,
  input  conv_types_pkg::pix_t  [KSIZE*KSIZE-1:0] win,
  input  conv_types_pkg::coef_t [KSIZE*KSIZE-1:0] weights,
  input  conv_types_pkg::shift_t                  shift,
  output conv_types_pkg::pix_stream_t             res
);

  import conv_types_pkg::*;

  localparam int NW = KSIZE * KSIZE;

  acc_t r_prod [NW];
  logic r_valid1;
  logic r_valid2;
  pix_t r_data2;
  acc_t sum;
  acc_t shifted;
  pix_t sat;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_valid1 <= 1'b0;
      r_valid2 <= 1'b0;
    end else begin
      r_valid1 <= win_valid;
      r_valid2 <= r_valid1;
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < NW; k++) begin
      r_prod[k] <= acc_t'($signed(win[k])) * acc_t'($signed(weights[k]));
    end
  end

  always_comb begin
    sum = '0;
    for (int k = 0; k < NW; k++) begin
      sum = sum + r_prod[k];
    end
    shifted = sum >>> shift; // arithmetic, rounds toward minus infinity
    if (shifted > acc_t'(PIX_MAX)) begin
      sat = PIX_MAX;
    end else if (shifted < acc_t'(PIX_MIN)) begin
      sat = PIX_MIN;
    end else begin
      sat = pix_t'(shifted);
    end
  end

  always_ff @(posedge clk) begin
    r_data2 <= sat;
  end

  assign res.valid = r_valid2;
  assign res.data  = r_data2;

endmodule

//--- src/conv_out.sv
`timescale 1ns/1ps

module conv_out #(
  parameter int KSIZE = 3
) (
  input  logic                        clk,
  input  logic                        xrst,
  input  logic                        start,
  input  conv_types_pkg::size_t       img_size,
  input  conv_types_pkg::pix_stream_t res,
  output conv_types_pkg::pix_stream_t res_out,
  input  logic                        res_ready,
  output logic                        space_ok,
  output logic                        busy,
  output logic                        done
);

  import conv_types_pkg::*;

  localparam int             DEPTH     = 8;
  localparam int             PW        = $clog2(DEPTH);
  localparam int             RW        = 2 * SWIDTH;
  localparam logic [PW:0]    HIGH_MARK = (PW+1)'(DEPTH - 4);

  pix_t          r_fifo [DEPTH];
  logic [PW-1:0] r_wptr;
  logic [PW-1:0] r_rptr;
  logic [PW:0]   r_count;
  logic [RW-1:0] r_remain;
  logic          r_busy;
  logic          r_done;
  logic          pop;
  size_t         dim;

  assign dim = img_size - size_t'(KSIZE - 1); // valid positions per line
  assign pop = r_count != '0 && res_ready;

  always_ff @(posedge clk) begin
    if (res.valid) begin
      r_fifo[r_wptr] <= res.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_wptr  <= '0;
      r_rptr  <= '0;
      r_count <= '0;
    end else begin
      if (res.valid) begin
        r_wptr <= r_wptr + 1'b1;
      end
      if (pop) begin
        r_rptr <= r_rptr + 1'b1;
      end
      r_count <= r_count + {{PW{1'b0}}, res.valid} - {{PW{1'b0}}, pop};
    end
  end

  // a result arriving this cycle already counts as stored
  assign space_ok = r_count + {{PW{1'b0}}, res.valid} <= HIGH_MARK;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_busy   <= 1'b0;
      r_done   <= 1'b0;
      r_remain <= '0;
    end else if (start) begin
      r_busy   <= 1'b1;
      r_done   <= 1'b0;
      r_remain <= dim * dim;
    end else if (pop && r_busy) begin
      r_remain <= r_remain - 1'b1;
      if (r_remain == RW'(1)) begin
        r_busy <= 1'b0;
        r_done <= 1'b1;
      end
    end
  end

  assign res_out.valid = r_count != '0;
  assign res_out.data  = r_fifo[r_rptr];
  assign busy          = r_busy;
  assign done          = r_done;

endmodule

//--- src/conv_regs_pkg.sv
package conv_regs_pkg;

  localparam int AXIL_AW = 8;
  localparam int AXIL_DW = 32;

  localparam logic [AXIL_AW-1:0] REG_CTRL        = 8'h00; // bit 0 starts an image
  localparam logic [AXIL_AW-1:0] REG_STATUS      = 8'h04; // bit 0 busy, bit 1 done
  localparam logic [AXIL_AW-1:0] REG_IMG_SIZE    = 8'h08;
  localparam logic [AXIL_AW-1:0] REG_SHIFT       = 8'h0C;
  localparam logic [AXIL_AW-1:0] REG_WEIGHT_BASE = 8'h10; // one word per weight, row-major

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic               awvalid;
    logic [AXIL_AW-1:0] awaddr;
    logic               wvalid;
    logic [AXIL_DW-1:0] wdata;
    logic [3:0]         wstrb;
    logic               bready;
    logic               arvalid;
    logic [AXIL_AW-1:0] araddr;
    logic               rready;
  } axil_req_t;

  typedef struct packed {
    logic               awready;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               arready;
    logic               rvalid;
    logic [AXIL_DW-1:0] rdata;
    logic [1:0]         rresp;
  } axil_rsp_t;

  typedef struct packed {
    conv_types_pkg::size_t  img_size;
    conv_types_pkg::shift_t shift;
  } cfg_t;

endpackage

//--- src/conv_top.sv
`timescale 1ns/1ps

module conv_top #(
  parameter int KSIZE    = 3,
  parameter int MAXWIDTH = 64
) (
  input  logic                        clk,
  input  logic                        xrst,
  input  conv_regs_pkg::axil_req_t    axil_req,
  output conv_regs_pkg::axil_rsp_t    axil_rsp,
  input  conv_types_pkg::pix_stream_t pix_in,
  output logic                        pix_ready,
  output conv_types_pkg::pix_stream_t res_out,
  input  logic                        res_ready
);

  import conv_types_pkg::*;
  import conv_regs_pkg::*;

  cfg_t                    cfg;
  coef_t [KSIZE*KSIZE-1:0] weights;
  pix_t  [KSIZE*KSIZE-1:0] win;
  pix_stream_t             pix_acc;
  pix_stream_t             res;
  logic                    start;
  logic                    busy;
  logic                    done;
  logic                    space_ok;
  logic                    win_valid;

  // input stalls here only, everything downstream runs freely
  assign pix_ready     = busy && space_ok;
  assign pix_acc.valid = pix_in.valid && pix_ready;
  assign pix_acc.data  = pix_in.data;

  cfg_axil_slave #(
    .KSIZE (KSIZE)
  ) i_cfg_axil_slave (
    .clk      (clk),
    .xrst     (xrst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cfg      (cfg),
    .weights  (weights),
    .start    (start),
    .busy     (busy),
    .done     (done)
  );

  linebuf #(
    .KSIZE    (KSIZE),
    .MAXWIDTH (MAXWIDTH)
  ) i_linebuf (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .img_size  (cfg.img_size),
    .pix_in    (pix_acc),
    .win_valid (win_valid),
    .win       (win)
  );

  conv_mac #(
    .KSIZE (KSIZE)
  ) i_conv_mac (
    .clk       (clk),
    .xrst      (xrst),
    .win_valid (win_valid),
    .win       (win),
    .weights   (weights),
    .shift     (cfg.shift),
    .res       (res)
  );

  conv_out #(
    .KSIZE (KSIZE)
  ) i_conv_out (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .img_size  (cfg.img_size),
    .res       (res),
    .res_out   (res_out),
    .res_ready (res_ready),
    .space_ok  (space_ok),
    .busy      (busy),
    .done      (done)
  );

endmodule

//--- src/conv_types_pkg.sv
package conv_types_pkg;

  localparam int DWIDTH = 16; // pixel width
  localparam int CWIDTH = 8;  // weight width
  localparam int AWIDTH = 32; // accumulator width
  localparam int SWIDTH = 10; // image dimension and position counters
  localparam int HWIDTH = 5;  // shift amount

  typedef logic signed [DWIDTH-1:0] pix_t;
  typedef logic signed [CWIDTH-1:0] coef_t;
  typedef logic signed [AWIDTH-1:0] acc_t;
  typedef logic        [SWIDTH-1:0] size_t;
  typedef logic        [HWIDTH-1:0] shift_t;

  // clamp limits for the output pixel
  localparam pix_t PIX_MAX = {1'b0, {(DWIDTH-1){1'b1}}};
  localparam pix_t PIX_MIN = {1'b1, {(DWIDTH-1){1'b0}}};

  typedef struct packed {
    logic valid;
    pix_t data;
  } pix_stream_t;

endpackage

//--- src/linebuf.sv
`timescale 1ns/1ps

module linebuf #(
  parameter int KSIZE    = 3,
  parameter int MAXWIDTH = 64
) (
  input  logic                                   clk,
  input  logic                                   xrst,
  input  logic                                   start,
  input  conv_types_pkg::size_t                  img_size,
  input  conv_types_pkg::pix_stream_t            pix_in,
  output logic                                   win_valid,
  output conv_types_pkg::pix_t [KSIZE*KSIZE-1:0] win
);

  import conv_types_pkg::*;

  localparam int    NL     = KSIZE - 1;
  localparam int    SELW   = (NL > 1) ? $clog2(NL) : 1;
  localparam size_t LAST_K = size_t'(KSIZE - 1);

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_FLUSH} state_t;

  state_t          r_state;
  size_t           r_col;
  size_t           r_row;
  logic [SELW-1:0] r_sel;   // line memory that receives the current row
  logic [SELW-1:0] r_sel_d;
  logic            r_acc_d;
  logic            r_pos_d;
  logic            r_win_valid;
  pix_t            r_pix;
  pix_t            r_win [KSIZE][KSIZE];
  pix_t            mem_rd [NL];
  pix_t            column [KSIZE];
  logic            accept;
  logic            col_end;
  logic            row_end;

  assign accept  = pix_in.valid && r_state == S_RUN;
  assign col_end = r_col == img_size - 1'b1;
  assign row_end = r_row == img_size - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state <= S_IDLE;
    end else begin
      case (r_state)
        S_IDLE: begin
          if (start) begin
            r_state <= S_RUN;
          end
        end
        S_RUN: begin
          if (accept && col_end && row_end) begin
            r_state <= S_FLUSH;
          end
        end
        S_FLUSH: r_state <= S_IDLE; // last column is still moving into the window
        default: r_state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst || start) begin
      r_col <= '0;
      r_row <= '0;
      r_sel <= '0;
    end else if (accept) begin
      if (col_end) begin
        r_col <= '0;
        r_row <= r_row + 1'b1;
        r_sel <= (r_sel == SELW'(NL - 1)) ? '0 : r_sel + 1'b1;
      end else begin
        r_col <= r_col + 1'b1;
      end
    end
  end

  for (genvar i = 0; i < NL; i++) begin : g_line
    mem_sp #(
      .DEPTH (MAXWIDTH)
    ) i_mem (
      .clk   (clk),
      .we    (accept && r_sel == SELW'(i)),
      .addr  (r_col),
      .wdata (pix_in.data),
      .rdata (mem_rd[i])
    );
  end

  // this stage lines the new pixel up with the memory read
  always_ff @(posedge clk) begin
    r_pix   <= pix_in.data;
    r_sel_d <= r_sel;
    r_pos_d <= r_col >= LAST_K && r_row >= LAST_K;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_acc_d     <= 1'b0;
      r_win_valid <= 1'b0;
    end else begin
      r_acc_d     <= accept;
      r_win_valid <= r_acc_d && r_pos_d;
    end
  end

  // the memory being overwritten still returns the oldest line
  always_comb begin
    int idx;
    column[KSIZE-1] = r_pix;
    for (int j = 1; j < KSIZE; j++) begin
      idx = int'(r_sel_d) + NL - j;
      if (idx >= NL) begin
        idx = idx - NL;
      end
      column[KSIZE-1-j] = mem_rd[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (r_acc_d) begin
      for (int i = 0; i < KSIZE; i++) begin
        for (int j = 0; j < KSIZE - 1; j++) begin
          r_win[i][j] <= r_win[i][j+1];
        end
        r_win[i][KSIZE-1] <= column[i];
      end
    end
  end

  // element 0 is the top-left pixel, the same order as the weights
  for (genvar i = 0; i < KSIZE; i++) begin : g_row
    for (genvar j = 0; j < KSIZE; j++) begin : g_col
      assign win[i*KSIZE+j] = r_win[i][j];
    end
  end

  assign win_valid = r_win_valid;

endmodule

//--- src/mem_sp.sv
`timescale 1ns/1ps

module mem_sp #(
  parameter int DEPTH = 64
) (
  input  logic                  clk,
  input  logic                  we,
  input  conv_types_pkg::size_t addr,
  input  conv_types_pkg::pix_t  wdata,
  output conv_types_pkg::pix_t  rdata
);

  import conv_types_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  pix_t mem [DEPTH];

  // read-first, the word stored before this write comes out next cycle
  always_ff @(posedge clk) begin
    rdata <= mem[addr[AW-1:0]];
    if (we) begin
      mem[addr[AW-1:0]] <= wdata;
    end
  end

endmodule

//--- verif/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;

  import conv_types_pkg::*;
  import conv_regs_pkg::*;

  localparam int KSIZE = 3;
  localparam int NW    = KSIZE * KSIZE;
  localparam int NCASE = 7;

  typedef struct packed {
    size_t      n;
    shift_t     shift;
    logic [1:0] wsel;      // 0 random, 1 all +127, 2 all -128, 3 small
    logic       stall;     // random res_ready
    logic [7:0] probe;     // address read to check the response code
    logic       probe_err;
  } case_t;

  localparam case_t CASES [NCASE] = '{
    '{10'd3, 5'd0,  2'd3, 1'b0, 8'h34, 1'b1},
    '{10'd5, 5'd4,  2'd0, 1'b0, 8'h08, 1'b0},
    '{10'd8, 5'd7,  2'd0, 1'b1, 8'hFC, 1'b1},
    '{10'd6, 5'd0,  2'd1, 1'b0, 8'h0C, 1'b0},
    '{10'd6, 5'd0,  2'd2, 1'b1, 8'h02, 1'b1},
    '{10'd8, 5'd12, 2'd1, 1'b1, 8'h30, 1'b0},
    '{10'd4, 5'd2,  2'd3, 1'b0, 8'h04, 1'b0}
  };

  logic        clk = 1'b0;
  logic        xrst;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  pix_stream_t pix_in;
  logic        pix_ready;
  pix_stream_t res_out;
  logic        res_ready;

  coef_t wts [NW];
  pix_t  pixels [$];
  pix_t  expected [$];
  int    value_errors = 0;
  int    other_errors = 0;
  logic  saw_backpressure = 1'b0;

  always #20 clk = ~clk;

  conv_top #(
    .KSIZE    (KSIZE),
    .MAXWIDTH (64)
  ) i_conv_top (
    .clk       (clk),
    .xrst      (xrst),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .pix_in    (pix_in),
    .pix_ready (pix_ready),
    .res_out   (res_out),
    .res_ready (res_ready)
  );

  function automatic longint watchdog_ns();
    longint total = 0;
    for (int i = 0; i < NCASE; i++) begin
      total += longint'(CASES[i].n) * longint'(CASES[i].n);
    end
    return total * 8 * 40 + 100000; // margin covers the register traffic
  endfunction

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int waited = 0;
    @(negedge clk);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hF;
    wait (axil_rsp.awready && axil_rsp.wready); // taken at the next rising edge
    @(negedge clk);
    while (!axil_rsp.bvalid && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    resp = axil_rsp.bresp;
    assert (axil_rsp.bvalid) else begin
      other_errors++;
      $display("write to address %h got no response", addr);
    end
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int waited = 0;
    @(negedge clk);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    wait (axil_rsp.arready); // taken at the next rising edge
    @(negedge clk);
    while (!axil_rsp.rvalid && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    axil_req.arvalid = 1'b0;
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    assert (axil_rsp.rvalid) else begin
      other_errors++;
      $display("read from address %h got no response", addr);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    assert (resp == RESP_OKAY) else begin
      value_errors++;
      $display("[FAIL] bresp @%h got %h exp %h", addr, resp, RESP_OKAY);
    end
  endtask

  task automatic check_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    assert (data == exp) else begin
      value_errors++;
      $display("[FAIL] %s rdata got %h exp %h", name, data, exp);
    end
    assert (resp == RESP_OKAY) else begin
      value_errors++;
      $display("[FAIL] %s rresp got %h exp %h", name, resp, RESP_OKAY);
    end
  endtask

  task automatic make_stimulus(input case_t tc);
    pixels.delete();
    for (int k = 0; k < NW; k++) begin
      case (tc.wsel)
        2'd0: wts[k] = coef_t'($urandom_range(0, 255));
        2'd1: wts[k] = 8'sd127;
        2'd2: wts[k] = -8'sd128;
        default: wts[k] = coef_t'(int'($urandom_range(0, 7)) - 4);
      endcase
    end
    for (int p = 0; p < int'(tc.n) * int'(tc.n); p++) begin
      if (tc.wsel == 2'd1 || tc.wsel == 2'd2) begin
        pixels.push_back(pix_t'(30000 + $urandom_range(0, 2767))); // near full scale
      end else if (tc.wsel == 2'd0) begin
        pixels.push_back(pix_t'(int'($urandom_range(0, 4095)) - 2048));
      end else begin
        pixels.push_back(pix_t'($urandom));
      end
    end
  endtask

  // weighted sum over each valid window, then an arithmetic shift and a clamp to 16 bits
  function automatic void model_results(input int n, input int sh);
    longint acc;
    expected.delete();
    for (int r = 0; r <= n - KSIZE; r++) begin
      for (int c = 0; c <= n - KSIZE; c++) begin
        acc = 0;
        for (int i = 0; i < KSIZE; i++) begin
          for (int j = 0; j < KSIZE; j++) begin
            acc += longint'(pixels[(r + i) * n + c + j]) * longint'(wts[i * KSIZE + j]);
          end
        end
        acc = acc >>> sh;
        if (acc > 32767) begin
          acc = 32767;
        end else if (acc < -32768) begin
          acc = -32768;
        end
        expected.push_back(pix_t'(acc));
      end
    end
  endfunction

  task automatic stream_image(input int n, input logic stall);
    int npix = n * n;
    int nres = expected.size();
    int pix_idx = 0;
    int res_idx = 0;
    int cycles = 0;
    while (res_idx < nres && cycles < npix * 8 + 100) begin
      @(negedge clk);
      cycles++;
      res_ready = stall ? 1'($urandom_range(0, 1)) : 1'b1;
      pix_in.valid = pix_idx < npix;
      if (pix_idx < npix) begin
        pix_in.data = pixels[pix_idx];
      end
      if (stall && pix_idx > 0 && pix_idx < npix && !pix_ready) begin
        saw_backpressure = 1'b1;
      end
      if (pix_in.valid && pix_ready) begin
        pix_idx++;
      end
      if (res_out.valid && res_ready) begin // leaves the FIFO on the next rising edge
        assert (res_out.data == expected[res_idx]) else begin
          value_errors++;
          $display("[FAIL] res_out.data #%0d got %h exp %h", res_idx, res_out.data,
                   expected[res_idx]);
        end
        res_idx++;
      end
    end
    assert (res_idx == nres) else begin
      other_errors++;
      $display("result stream stopped after %0d of %0d results", res_idx, nres);
    end
    @(negedge clk);
    pix_in.valid = 1'b0;
    res_ready    = 1'b1;
  endtask

  initial begin
    #(watchdog_ns());
    $display("timeout, the run did not finish in the expected time");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    case_t       tc;
    logic [31:0] data;
    logic [1:0]  resp;
    void'($urandom(32'h9b34));
    xrst      = 1'b0;
    axil_req  = '0;
    pix_in    = '0;
    res_ready = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    assert (!pix_ready && !res_out.valid && !axil_rsp.bvalid && !axil_rsp.rvalid) else begin
      other_errors++;
      $display("outputs are not idle after reset");
    end
    check_reg("status", REG_STATUS, 32'h0);

    for (int c = 0; c < NCASE; c++) begin
      tc = CASES[c];
      make_stimulus(tc);
      write_reg(REG_IMG_SIZE, 32'(tc.n));
      write_reg(REG_SHIFT, 32'(tc.shift));
      for (int k = 0; k < NW; k++) begin
        write_reg(REG_WEIGHT_BASE + 8'(4 * k), {{24{wts[k][7]}}, wts[k]});
      end
      check_reg("img_size", REG_IMG_SIZE, 32'(tc.n));
      check_reg("shift", REG_SHIFT, 32'(tc.shift));
      for (int k = 0; k < NW; k++) begin
        check_reg($sformatf("weight[%0d]", k), REG_WEIGHT_BASE + 8'(4 * k),
                  {{24{wts[k][7]}}, wts[k]});
      end
      axil_read(tc.probe, data, resp);
      assert (resp == (tc.probe_err ? RESP_SLVERR : RESP_OKAY)) else begin
        value_errors++;
        $display("[FAIL] rresp @%h got %h exp %h", tc.probe, resp,
                 tc.probe_err ? RESP_SLVERR : RESP_OKAY);
      end
      model_results(int'(tc.n), int'(tc.shift));

      write_reg(REG_CTRL, 32'h1);
      check_reg("status", REG_STATUS, 32'h1);
      write_reg(REG_IMG_SIZE, 32'(tc.n + 1'b1)); // frozen while the image runs
      check_reg("img_size", REG_IMG_SIZE, 32'(tc.n));
      write_reg(REG_SHIFT, 32'(tc.shift + 1'b1));
      check_reg("shift", REG_SHIFT, 32'(tc.shift));
      write_reg(REG_WEIGHT_BASE, ~{{24{wts[0][7]}}, wts[0]});
      check_reg("weight[0]", REG_WEIGHT_BASE, {{24{wts[0][7]}}, wts[0]});

      stream_image(int'(tc.n), tc.stall);
      check_reg("status", REG_STATUS, 32'h2);
      assert (!res_out.valid) else begin
        other_errors++;
        $display("extra result present after done in case %0d", c);
      end
    end

    assert (saw_backpressure) else begin
      other_errors++;
      $display("pix_ready never fell while results were stalled");
    end

    $display("errors: value %0d, other %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
